// ==== testbench/mem_trace.txt ====
// test pc insn rs1 rs2 d_trap d_cause | expected q_rd_val q_trap q_cause
// all values hex, one instruction per line
1 00 00002023 00000010 11223344 0 0 00000010 0 0
1 04 00002023 00000014 a5a5a5a5 0 0 00000014 0 0
1 08 00002003 00000010 00000000 0 0 11223344 0 0
1 0c 00002003 00000014 00000000 0 0 a5a5a5a5 0 0
2 10 00000023 00000021 000000ab 0 0 00000021 0 0
2 14 00001023 00000022 00008001 0 0 00000022 0 0
2 18 00002003 00000020 00000000 0 0 8001ab00 0 0
2 1c 00000003 00000021 00000000 0 0 ffffffab 0 0
2 20 00004003 00000021 00000000 0 0 000000ab 0 0
2 24 00001003 00000022 00000000 0 0 ffff8001 0 0
2 28 00005003 00000022 00000000 0 0 00008001 0 0
3 2c 00001003 00000021 00000000 0 0 00000021 1 4
3 30 00002003 00000022 00000000 0 0 00000022 1 4
3 34 00002023 00000012 deadbeef 0 0 00000012 1 6
3 38 00002003 00000010 00000000 0 0 11223344 0 0
4 3c 00002023 00000040 80000005 0 0 00000040 0 0
4 40 0000202f 00000040 00000003 0 0 80000005 0 0
4 44 2000202f 00000040 0000000f 0 0 80000008 0 0
4 48 4000202f 00000040 00000100 0 0 80000007 0 0
4 4c 6000202f 00000040 ffff00ff 0 0 80000107 0 0
4 50 8000202f 00000040 00000001 0 0 80000007 0 0
4 54 a000202f 00000040 00000001 0 0 80000007 0 0
4 58 e000202f 00000040 90000000 0 0 00000001 0 0
4 5c c000202f 00000040 7fffffff 0 0 90000000 0 0
4 60 00002003 00000040 00000000 0 0 7fffffff 0 0
5 64 0800202f 00000010 cafef00d 0 0 11223344 0 0
5 68 00002003 00000010 00000000 0 0 cafef00d 0 0
5 6c 1000202f 00000010 00000000 0 0 00000010 1 2
5 70 1800202f 00000010 00000000 0 0 00000010 1 2
6 74 00000013 12345678 00000000 0 0 12345678 0 0
6 78 00002003 00000010 00000000 1 5 00000010 1 5
6 7c 00002023 00000010 00000000 1 7 00000010 1 7
6 80 00002003 00000010 00000000 0 0 cafef00d 0 0

// ==== files.f ====
common/mem_pkg.sv
hw/mem_decode.sv
mem_access/amo_alu.sv
mem_access/mem_access.sv
hw/mem_stage.sv
testbench/data_memory.sv
testbench/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_mem_stage
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_bin
	./obj_dir/sim_bin | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_mem_stage.sv ====
// Trace-driven testbench for the data-memory stage; run through the Makefile sim target.
`timescale 1ns/1ps

module tb_mem_stage;
    localparam int fields = 10;
    localparam int max_lines = 64;

    logic              clk;
    logic              rst;
    logic              d_valid;
    mem_pkg::pc_t      d_pc;
    mem_pkg::insn_t    d_insn;
    logic              d_use_rd;
    mem_pkg::word_t    d_rs1_val;
    mem_pkg::word_t    d_rs2_val;
    logic              d_trap;
    mem_pkg::cause_t   d_cause;
    logic              mem_ready;
    mem_pkg::word_t    mem_rdata;
    logic              q_valid;
    mem_pkg::pc_t      q_pc;
    mem_pkg::insn_t    q_insn;
    logic              q_use_rd;
    mem_pkg::word_t    q_rd_val;
    logic              q_trap;
    mem_pkg::cause_t   q_cause;
    logic              stall_req;
    logic              mem_re;
    logic [3:0]        mem_we;
    mem_pkg::addr_t    mem_addr;
    mem_pkg::word_t    mem_wdata;

    // Ten words per line, from the test number to the expected cause.
    mem_pkg::word_t trace [0:fields*max_lines-1];
    int n_lines;
    int n_results;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int cycles;
    int limit;
    int base;
    int idx;
    int k;

    mem_stage dut (
        .clk (clk), .rst (rst), .d_valid (d_valid), .d_pc (d_pc), .d_insn (d_insn),
        .d_use_rd (d_use_rd), .d_rs1_val (d_rs1_val), .d_rs2_val (d_rs2_val),
        .d_trap (d_trap), .d_cause (d_cause), .mem_ready (mem_ready), .mem_rdata (mem_rdata),
        .q_valid (q_valid), .q_pc (q_pc), .q_insn (q_insn), .q_use_rd (q_use_rd),
        .q_rd_val (q_rd_val), .q_trap (q_trap), .q_cause (q_cause), .stall_req (stall_req),
        .mem_re (mem_re), .mem_we (mem_we), .mem_addr (mem_addr), .mem_wdata (mem_wdata)
    );

    data_memory memory (
        .clk (clk), .rst (rst), .re (mem_re), .we (mem_we), .addr (mem_addr),
        .wdata (mem_wdata), .ready (mem_ready), .rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic apply_line(input int line);
        int b;
        b = line * fields;
        d_valid   <= 1'b1;
        d_pc      <= trace[b+1][31:1];
        d_insn    <= trace[b+2];
        // The rd flag alternates with the line index.
        d_use_rd  <= line[0];
        d_rs1_val <= trace[b+3];
        d_rs2_val <= trace[b+4];
        d_trap    <= trace[b+5][0];
        d_cause   <= trace[b+6][3:0];
    endtask

    // Results are compared in trace order at each delivery cycle.
    always @(posedge clk) begin
        if (!rst && !stall_req && (q_valid || q_trap) && n_results < n_lines) begin
            base = n_results * fields;
            check("q_pc", {q_pc, 1'b0}, trace[base+1]);
            check("q_insn", q_insn, trace[base+2]);
            check("q_use_rd", {31'd0, q_use_rd}, {31'd0, n_results[0]});
            check("q_rd_val", q_rd_val, trace[base+7]);
            // A trapped instruction delivers with q_valid low.
            check("q_valid", {31'd0, q_valid}, {31'd0, ~trace[base+8][0]});
            check("q_trap", {31'd0, q_trap}, trace[base+8]);
            check("q_cause", {28'd0, q_cause}, trace[base+9]);
            if (n_results + 1 == n_lines || trace[base+fields] != trace[base]) begin
                $display("test %0d %s", trace[base], test_errors == 0 ? "passed" : "failed");
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                test_errors = 0;
            end
            n_results++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: only %0d of %0d results arrived", n_results, n_lines);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        d_valid = 1'b0;
        d_pc = '0;
        d_insn = '0;
        d_use_rd = 1'b0;
        d_rs1_val = '0;
        d_rs2_val = '0;
        d_trap = 1'b0;
        d_cause = '0;
        n_lines = 0;
        n_results = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        limit = 0;
        // Slots the file leaves untouched keep an address-dependent marker.
        for (k = 0; k < fields * max_lines; k++) begin
            trace[k] = ~mem_pkg::word_t'(k);
        end
        $readmemh("testbench/mem_trace.txt", trace);
        while (n_lines < max_lines &&
               trace[n_lines*fields] != ~mem_pkg::word_t'(n_lines * fields)) begin
            n_lines++;
        end
        limit = n_lines * 16 + 100;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        if (n_lines == 0) begin
            $display("the trace file holds no instructions");
            errors++;
        end else begin
            idx = 0;
            apply_line(0);
            // Next line only after an edge that accepted the current one.
            while (idx < n_lines) begin
                @(posedge clk);
                if (!stall_req) begin
                    idx++;
                    if (idx < n_lines) begin
                        apply_line(idx);
                    end else begin
                        d_valid <= 1'b0;
                    end
                end
            end
            wait (n_results == n_lines);
        end
        @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/data_memory.sv ====
// Behavioral data memory for the testbench, 256 words with byte writes and random wait states.
`timescale 1ns/1ps

module data_memory (
    input  logic              clk,
    input  logic              rst,
    input  logic              re,
    input  logic [3:0]        we,
    input  mem_pkg::addr_t    addr,
    input  mem_pkg::word_t    wdata,
    output logic              ready,
    output mem_pkg::word_t    rdata
);
    mem_pkg::word_t words [0:255];
    logic           active;
    logic [1:0]     wait_cnt;
    logic [31:0]    rnd_state;
    logic [31:0]    rnd_next;
    int             i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Read data is valid whenever the bus address is stable.
    assign rdata = words[addr[9:2]];

    always @(posedge clk) begin
        if (rst) begin
            ready     <= 1'b0;
            active    <= 1'b0;
            wait_cnt  <= 2'd0;
            rnd_state <= 32'h7e51_b91b;
            for (i = 0; i < 256; i++) begin
                words[i] <= '0;
            end
        end else if (ready) begin
            // Byte enables take effect on the ready cycle.
            for (i = 0; i < 4; i++) begin
                if (we[i]) begin
                    words[addr[9:2]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
            ready  <= 1'b0;
            active <= 1'b0;
        end else if (!active && (re || we != 4'b0000)) begin
            rnd_next  = xorshift(rnd_state);
            rnd_state <= rnd_next;
            active    <= 1'b1;
            wait_cnt  <= rnd_next[1:0];
            ready     <= rnd_next[1:0] == 2'd0;
        end else if (active) begin
            wait_cnt <= wait_cnt - 2'd1;
            if (wait_cnt == 2'd1) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/mem_stage.sv ====
// Data-memory pipeline stage top; sits between execute and writeback and drives the data bus.
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              d_valid,
    input  mem_pkg::pc_t      d_pc,
    input  mem_pkg::insn_t    d_insn,
    input  logic              d_use_rd,
    input  mem_pkg::word_t    d_rs1_val,
    input  mem_pkg::word_t    d_rs2_val,
    input  logic              d_trap,
    input  mem_pkg::cause_t   d_cause,
    input  logic              mem_ready,
    input  mem_pkg::word_t    mem_rdata,
    output logic              q_valid,
    output mem_pkg::pc_t      q_pc,
    output mem_pkg::insn_t    q_insn,
    output logic              q_use_rd,
    output mem_pkg::word_t    q_rd_val,
    output logic              q_trap,
    output mem_pkg::cause_t   q_cause,
    output logic              stall_req,
    output logic              mem_re,
    output mem_pkg::byte_en_t mem_we,
    output mem_pkg::addr_t    mem_addr,
    output mem_pkg::word_t    mem_wdata
);
    logic              dec_load;
    logic              dec_store;
    logic              dec_rmw;
    logic              dec_swap;
    mem_pkg::size_t    dec_size;
    logic              dec_sign;
    mem_pkg::rmw_op_t  dec_rmw_op;
    logic              dec_misaligned;
    logic              dec_illegal;

    logic              issue;
    logic              acc_busy;
    logic              acc_done;
    mem_pkg::word_t    acc_rdata;

    // Barrier register contents.
    logic              r_valid;
    mem_pkg::pc_t      r_pc;
    mem_pkg::insn_t    r_insn;
    logic              r_use_rd;
    mem_pkg::word_t    r_rs1_val;
    logic              r_mem_rd;

    logic              trap;
    mem_pkg::cause_t   cause;
    logic              next_trap;
    mem_pkg::cause_t   next_cause;

    mem_decode u_decode (
        .d_valid    (d_valid),
        .d_trap     (d_trap),
        .insn       (d_insn),
        .addr       (d_rs1_val),
        .load       (dec_load),
        .store      (dec_store),
        .rmw        (dec_rmw),
        .swap       (dec_swap),
        .size       (dec_size),
        .sign       (dec_sign),
        .rmw_op     (dec_rmw_op),
        .misaligned (dec_misaligned),
        .illegal    (dec_illegal)
    );

    // Start a bus access when the instruction is accepted.
    assign issue = !stall_req && (dec_load || dec_store || dec_rmw || dec_swap);

    mem_access u_access (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .load      (dec_load),
        .store     (dec_store),
        .rmw       (dec_rmw),
        .swap      (dec_swap),
        .size      (dec_size),
        .sign      (dec_sign),
        .rmw_op    (dec_rmw_op),
        .addr      (d_rs1_val),
        .wdata     (d_rs2_val),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .busy      (acc_busy),
        .done      (acc_done),
        .rdata     (acc_rdata),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // The stage waits only on its own outstanding access.
    assign stall_req = acc_busy;

    // Trap priority: incoming, illegal, load align, store align.
    always_comb begin
        next_trap  = 1'b1;
        next_cause = d_cause;
        if (d_trap) begin
            next_cause = d_cause;
        end else if (dec_illegal) begin
            next_cause = mem_pkg::cause_illegal;
        end else if (dec_misaligned && d_insn[6:2] == mem_pkg::op_load) begin
            next_cause = mem_pkg::cause_load_align;
        end else if (dec_misaligned) begin
            next_cause = mem_pkg::cause_store_align;
        end else begin
            next_trap  = 1'b0;
            next_cause = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
            trap    <= 1'b0;
        end else if (!stall_req) begin
            r_valid <= d_valid;
            trap    <= next_trap;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_req) begin
            r_pc      <= d_pc;
            r_insn    <= d_insn;
            r_use_rd  <= d_use_rd;
            r_rs1_val <= d_rs1_val;
            r_mem_rd  <= dec_load || dec_rmw || dec_swap;
            cause     <= next_cause;
        end
    end

    assign q_valid  = r_valid && !trap;
    assign q_pc     = r_pc;
    assign q_insn   = r_insn;
    assign q_use_rd = r_use_rd;
    assign q_trap   = trap;
    assign q_cause  = cause;

    // Stores and non-memory instructions return rs1.
    assign q_rd_val = r_mem_rd ? acc_rdata : r_rs1_val;

    // A stall always belongs to the instruction held in the barrier.
    a_stall_needs_valid: assert property (@(posedge clk) disable iff (rst)
        stall_req |-> r_valid && !acc_done);

endmodule

// ==== mem_access/mem_access.sv ====
// Data bus sequencer: holds a request until ready, runs atomics as read then write, aligns lanes.
`timescale 1ns/1ps

module mem_access (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  logic                load,
    input  logic                store,
    input  logic                rmw,
    input  logic                swap,
    input  mem_pkg::size_t      size,
    input  logic                sign,
    input  mem_pkg::rmw_op_t    rmw_op,
    input  mem_pkg::addr_t      addr,
    input  mem_pkg::word_t      wdata,
    input  logic                mem_ready,
    input  mem_pkg::word_t      mem_rdata,
    output logic                busy,
    output logic                done,
    output mem_pkg::word_t      rdata,
    output logic                mem_re,
    output mem_pkg::byte_en_t   mem_we,
    output mem_pkg::addr_t      mem_addr,
    output mem_pkg::word_t      mem_wdata
);
    logic                pend;
    mem_pkg::amo_phase_e phase;

    // Latched request.
    logic                p_rd;
    logic                p_wr;
    logic                p_rmw;
    mem_pkg::size_t      p_size;
    logic                p_sign;
    mem_pkg::rmw_op_t    p_op;
    mem_pkg::addr_t      p_addr;
    mem_pkg::word_t      p_wdata;
    mem_pkg::word_t      old_reg;

    // Request currently on the bus.
    logic                cur_rd;
    logic                cur_wr;
    logic                cur_rmw;
    mem_pkg::size_t      cur_size;
    mem_pkg::addr_t      cur_addr;
    mem_pkg::word_t      cur_wdata;
    logic                write_phase;
    logic                wr_req;
    mem_pkg::word_t      wr_data;
    mem_pkg::word_t      alu_result;
    mem_pkg::byte_en_t   lane_we;
    mem_pkg::word_t      shifted;
    mem_pkg::word_t      ext_data;

    // The held request wins over a new issue.
    assign cur_rd    = pend ? p_rd : issue && (load || swap || rmw);
    assign cur_wr    = pend ? p_wr : issue && (store || swap);
    assign cur_rmw   = pend ? p_rmw : issue && rmw;
    assign cur_size  = pend ? p_size : size;
    assign cur_addr  = pend ? p_addr : addr;
    assign cur_wdata = pend ? p_wdata : wdata;

    assign write_phase = cur_rmw && phase == mem_pkg::phase_write;
    assign wr_req      = cur_wr || write_phase;
    assign wr_data     = write_phase ? alu_result : cur_wdata;

    // The read half of an atomic does not complete the instruction.
    assign done = pend && mem_ready && !(p_rmw && phase == mem_pkg::phase_read);
    assign busy = pend && !done;

    amo_alu u_alu (
        .op      (p_op),
        .old     (old_reg),
        .operand (p_wdata),
        .result  (alu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pend  <= 1'b0;
            phase <= mem_pkg::phase_read;
        end else begin
            if (done) begin
                pend  <= 1'b0;
                phase <= mem_pkg::phase_read;
            end else if (pend && p_rmw && mem_ready) begin
                phase <= mem_pkg::phase_write;
            end
            if (issue) begin
                pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            p_rd    <= load || swap || rmw;
            p_wr    <= store || swap;
            p_rmw   <= rmw;
            p_size  <= size;
            p_sign  <= sign;
            p_op    <= rmw_op;
            p_addr  <= addr;
            p_wdata <= wdata;
        end
        // Old value for the atomic's write phase and its result.
        if (pend && p_rmw && phase == mem_pkg::phase_read && mem_ready) begin
            old_reg <= mem_rdata;
        end
    end

    // Write lane placement.
    always_comb begin
        case (cur_size)
            mem_pkg::size_byte: begin
                mem_wdata = {4{wr_data[7:0]}};
                lane_we   = mem_pkg::byte_en_t'(4'b0001 << cur_addr[1:0]);
            end
            mem_pkg::size_half: begin
                mem_wdata = {2{wr_data[15:0]}};
                lane_we   = cur_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_wdata = wr_data;
                lane_we   = 4'b1111;
            end
        endcase
    end

    assign mem_re   = cur_rd && !write_phase;
    assign mem_we   = wr_req ? lane_we : 4'b0000;
    assign mem_addr = {cur_addr[31:2], 2'b00};

    // Load extraction from the latched offset.
    always_comb begin
        shifted = mem_rdata >> {p_addr[1:0], 3'b000};
        case (p_size)
            mem_pkg::size_byte: ext_data = {{24{p_sign && shifted[7]}}, shifted[7:0]};
            mem_pkg::size_half: ext_data = {{16{p_sign && shifted[15]}}, shifted[15:0]};
            default:            ext_data = mem_rdata;
        endcase
    end

    // Atomics return the value read in the first phase.
    assign rdata = p_rmw ? old_reg : ext_data;

    // Misaligned word writes must have been stopped by the decoder.
    a_word_write_aligned: assert property (@(posedge clk) disable iff (rst)
        (mem_we != 4'b0000 && cur_size == mem_pkg::size_word) |-> cur_addr[1:0] == 2'b00);

    a_no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        issue |-> !busy);

endmodule

// ==== mem_access/amo_alu.sv ====
// Atomic read-modify-write value calculator, used by the bus sequencer during the write phase.
`timescale 1ns/1ps

module amo_alu (
    input  mem_pkg::rmw_op_t op,
    input  mem_pkg::word_t   old,
    input  mem_pkg::word_t   operand,
    output mem_pkg::word_t   result
);
    logic           sub;
    logic           flip;
    mem_pkg::word_t lhs;
    mem_pkg::word_t rhs;
    logic [32:0]    sum;
    logic           old_ge;

    // Compares subtract; signed ones flip the MSBs first.
    assign sub  = op != mem_pkg::rmw_add;
    assign flip = op == mem_pkg::rmw_min || op == mem_pkg::rmw_max;

    always_comb begin
        lhs = old;
        rhs = sub ? ~operand : operand;
        if (flip) begin
            lhs[31] = ~lhs[31];
            rhs[31] = ~rhs[31];
        end
        sum = {1'b0, lhs} + {1'b0, rhs} + {32'd0, sub};
    end

    // Carry out of old - operand means old >= operand.
    assign old_ge = sum[32];

    always_comb begin
        case (op)
            mem_pkg::rmw_add:  result = sum[31:0];
            mem_pkg::rmw_xor:  result = old ^ operand;
            mem_pkg::rmw_or:   result = old | operand;
            mem_pkg::rmw_and:  result = old & operand;
            mem_pkg::rmw_min:  result = old_ge ? operand : old;
            mem_pkg::rmw_max:  result = old_ge ? old : operand;
            mem_pkg::rmw_minu: result = old_ge ? operand : old;
            default:           result = old_ge ? old : operand;
        endcase
    end

endmodule

// ==== hw/mem_decode.sv ====
// Combinational load, store and atomic decoder feeding the data-memory stage top and bus sequencer.
`timescale 1ns/1ps

module mem_decode (
    input  logic              d_valid,
    input  logic              d_trap,
    input  mem_pkg::insn_t    insn,
    input  mem_pkg::addr_t    addr,
    output logic              load,
    output logic              store,
    output logic              rmw,
    output logic              swap,
    output mem_pkg::size_t    size,
    output logic              sign,
    output mem_pkg::rmw_op_t  rmw_op,
    output logic              misaligned,
    output logic              illegal
);
    logic active;
    logic is_load;
    logic is_store;
    logic is_rmw;
    logic is_swap;

    // Only live instructions without an earlier trap decode.
    assign active = d_valid && !d_trap;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_rmw   = 1'b0;
        is_swap  = 1'b0;
        illegal  = 1'b0;
        if (active) begin
            if (insn[6:2] == mem_pkg::op_load) begin
                is_load = 1'b1;
            end else if (insn[6:2] == mem_pkg::op_store) begin
                is_store = 1'b1;
            end else if (insn[6:2] == mem_pkg::op_amo) begin
                // LR and SC are not supported.
                case (insn[28:27])
                    2'b00:   is_rmw  = 1'b1;
                    2'b01:   is_swap = 1'b1;
                    default: illegal = 1'b1;
                endcase
            end
        end
    end

    // Atomics are always word sized.
    assign size   = (is_rmw || is_swap) ? mem_pkg::size_word : insn[13:12];
    assign sign   = !insn[14];
    assign rmw_op = insn[31:29];

    assign misaligned = (is_load || is_store || is_rmw || is_swap) &&
                        ((size == mem_pkg::size_half && addr[0]) ||
                         (size == mem_pkg::size_word && addr[1:0] != 2'b00));

    // A misaligned access never reaches the bus.
    assign load  = is_load && !misaligned;
    assign store = is_store && !misaligned;
    assign rmw   = is_rmw && !misaligned;
    assign swap  = is_swap && !misaligned;

endmodule

// ==== common/mem_pkg.sv ====
// Shared types, opcodes, trap causes and atomic phase encoding, used by every data-memory stage file.
package mem_pkg;

    // Data word for register values, memory data and results.
    typedef logic [31:0] word_t;

    // Byte address.
    typedef logic [31:0] addr_t;

    // Instruction address, bits 31 to 1.
    typedef logic [31:1] pc_t;

    // Raw instruction word.
    typedef logic [31:0] insn_t;

    // Trap cause code.
    typedef logic [3:0] cause_t;

    // Access size as encoded in funct3[1:0].
    typedef logic [1:0] size_t;

    // Atomic arithmetic selector from insn[31:29].
    typedef logic [2:0] rmw_op_t;

    // Write byte enables, one per lane.
    typedef logic [3:0] byte_en_t;

    // Major opcodes, insn[6:2].
    localparam logic [4:0] op_load  = 5'b00000;
    localparam logic [4:0] op_store = 5'b01000;
    localparam logic [4:0] op_amo   = 5'b01011;

    // Access sizes.
    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    // Trap causes raised by this stage.
    localparam cause_t cause_illegal     = 4'd2;
    localparam cause_t cause_load_align  = 4'd4;
    localparam cause_t cause_store_align = 4'd6;

    // Atomic ops, in insn[31:29] order.
    localparam rmw_op_t rmw_add  = 3'd0;
    localparam rmw_op_t rmw_xor  = 3'd1;
    localparam rmw_op_t rmw_or   = 3'd2;
    localparam rmw_op_t rmw_and  = 3'd3;
    localparam rmw_op_t rmw_min  = 3'd4;
    localparam rmw_op_t rmw_max  = 3'd5;
    localparam rmw_op_t rmw_minu = 3'd6;
    localparam rmw_op_t rmw_maxu = 3'd7;

    // Read-modify-write sequencer phase.
    typedef enum logic {
        phase_read,
        phase_write
    } amo_phase_e;

endpackage
